//--- Makefile
SIM_DIR = obj_dir
SIM_BIN = tb_sim

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f src.f --top-module tb_rv_core \
		--Mdir $(SIM_DIR) -o $(SIM_BIN)
	@out=$$(./$(SIM_DIR)/$(SIM_BIN)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation finished: PASS"

clean:
	rm -rf $(SIM_DIR)

//--- design/alu.sv
`timescale 1ns/1ps

module alu (
  input  rv_pkg::decoded_t dec,
  input  rv_pkg::word_t    rs1_data,
  input  rv_pkg::word_t    rs2_data,
  output rv_pkg::word_t    wdata
);

  rv_pkg::word_t op_b;
  logic [4:0]    shamt;

  assign op_b  = dec.use_imm ? dec.imm : rs2_data;
  assign shamt = op_b[4:0];   // only the low five bits shift

  always_comb begin
    case (dec.alu_op)
      rv_pkg::ALU_ADD:  wdata = rs1_data + op_b;
      rv_pkg::ALU_SUB:  wdata = rs1_data - op_b;
      rv_pkg::ALU_SLL:  wdata = rs1_data << shamt;
      rv_pkg::ALU_SLT:  wdata = {31'd0, $signed(rs1_data) < $signed(op_b)};
      rv_pkg::ALU_SLTU: wdata = {31'd0, rs1_data < op_b};
      rv_pkg::ALU_XOR:  wdata = rs1_data ^ op_b;
      rv_pkg::ALU_SRL:  wdata = rs1_data >> shamt;
      rv_pkg::ALU_SRA:  wdata = $unsigned($signed(rs1_data) >>> shamt);
      rv_pkg::ALU_OR:   wdata = rs1_data | op_b;
      rv_pkg::ALU_AND:  wdata = rs1_data & op_b;
      rv_pkg::ALU_LUI:  wdata = op_b;     // upper immediate passes through
      default:          wdata = '0;
    endcase
  end

endmodule

//--- design/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit (
  input  logic             clk,
  input  logic             rst,
  input  logic             exec,
  input  logic             pc_clear,
  input  rv_pkg::decoded_t dec,
  input  rv_pkg::word_t    rs1_data,
  input  rv_pkg::word_t    rs2_data,
  output rv_pkg::word_t    pc
);

  logic          cond;
  logic          take_branch;
  rv_pkg::word_t pc_next;

  // branch condition selected by funct3
  always_comb begin
    case (dec.funct3)
      3'b000:  cond = (rs1_data == rs2_data);                    // beq
      3'b001:  cond = (rs1_data != rs2_data);                    // bne
      3'b100:  cond = ($signed(rs1_data) < $signed(rs2_data));   // blt
      3'b101:  cond = ($signed(rs1_data) >= $signed(rs2_data));  // bge
      3'b110:  cond = (rs1_data < rs2_data);                     // bltu
      3'b111:  cond = (rs1_data >= rs2_data);                    // bgeu
      default: cond = 1'b0;
    endcase
  end

  assign take_branch = dec.is_branch && cond;
  assign pc_next     = take_branch ? pc + dec.br_off : pc + 32'd4;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= '0;
    end else if (pc_clear) begin
      pc <= '0;        // new run starts at address 0
    end else if (exec) begin
      pc <= pc_next;
    end
  end

endmodule

//--- design/insn_decode.sv
`timescale 1ns/1ps

module insn_decode (
  input  rv_pkg::word_t    insn,
  output rv_pkg::decoded_t dec
);

  logic [6:0] funct7;
  logic       f7_ok;   // funct7 is 0 or 0x20

  assign funct7 = insn[31:25];
  assign f7_ok  = (funct7 == 7'h00) || (funct7 == 7'h20);

  always_comb begin
    dec            = '0;
    dec.rs1        = insn[19:15];
    dec.rs2        = insn[24:20];
    dec.rd         = insn[11:7];
    dec.funct3     = insn[14:12];
    dec.imm        = {{20{insn[31]}}, insn[31:20]};
    dec.br_off     = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
    dec.alu_op     = rv_pkg::ALU_ADD;

    case (insn[6:0])
      rv_pkg::OP_LUI: begin
        dec.imm     = {insn[31:12], 12'b0};
        dec.use_imm = 1'b1;
        dec.alu_op  = rv_pkg::ALU_LUI;
        dec.rd_we   = 1'b1;
      end
      rv_pkg::OP_REG_IMM: begin
        dec.use_imm = 1'b1;
        dec.rd_we   = 1'b1;
        case (insn[14:12])
          3'b000: dec.alu_op = rv_pkg::ALU_ADD;
          3'b010: dec.alu_op = rv_pkg::ALU_SLT;
          3'b011: dec.alu_op = rv_pkg::ALU_SLTU;
          3'b100: dec.alu_op = rv_pkg::ALU_XOR;
          3'b110: dec.alu_op = rv_pkg::ALU_OR;
          3'b111: dec.alu_op = rv_pkg::ALU_AND;
          3'b001: begin
            dec.alu_op     = rv_pkg::ALU_SLL;
            dec.is_illegal = (funct7 != 7'h00);
          end
          default: begin // 3'b101, srli or srai
            dec.alu_op     = insn[30] ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
            dec.is_illegal = !f7_ok;
          end
        endcase
      end
      rv_pkg::OP_REG_REG: begin
        dec.rd_we      = 1'b1;
        dec.is_illegal = !f7_ok;
        case (insn[14:12])
          3'b000:  dec.alu_op = insn[30] ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
          3'b001:  dec.alu_op = rv_pkg::ALU_SLL;
          3'b010:  dec.alu_op = rv_pkg::ALU_SLT;
          3'b011:  dec.alu_op = rv_pkg::ALU_SLTU;
          3'b100:  dec.alu_op = rv_pkg::ALU_XOR;
          3'b101:  dec.alu_op = insn[30] ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
          3'b110:  dec.alu_op = rv_pkg::ALU_OR;
          default: dec.alu_op = rv_pkg::ALU_AND;
        endcase
      end
      rv_pkg::OP_BRANCH: begin
        dec.is_branch  = 1'b1;
        dec.is_illegal = (insn[14:13] == 2'b01); // funct3 2 and 3 are reserved
      end
      rv_pkg::OP_ENVIRON: begin
        // only a plain ecall is accepted
        dec.is_halt    = (insn[31:7] == 25'd0);
        dec.is_illegal = (insn[31:7] != 25'd0);
      end
      default: dec.is_illegal = 1'b1;
    endcase

    // nothing reaches the register file for these, x0 included
    if (dec.is_illegal || dec.is_halt || dec.is_branch || dec.rd == '0) begin
      dec.rd_we = 1'b0;
    end
  end

endmodule

//--- design/instr_mem.sv
`timescale 1ns/1ps

module instr_mem (
  input  logic             clk,
  input  rv_pkg::prog_wr_t mem_wr,
  input  rv_pkg::word_t    pc,
  output rv_pkg::word_t    insn
);

  rv_pkg::word_t      mem [rv_pkg::IMEM_WORDS];
  rv_pkg::imem_addr_t rd_addr;

  assign rd_addr = pc[7:2]; // word index, byte offset dropped
  assign insn    = mem[rd_addr];

  // program load port, only open while the core is not running
  always_ff @(posedge clk) begin
    if (mem_wr.valid) begin
      mem[mem_wr.addr] <= mem_wr.data;
    end
  end

  // fetch must stay word aligned
  a_pc_aligned: assert property (@(posedge clk) pc[1:0] == 2'b00)
    else $error("instr_mem: misaligned pc %h", pc);

endmodule

//--- design/reg_file.sv
`timescale 1ns/1ps

module reg_file (
  input  logic             clk,
  input  logic             rst,
  input  logic             we,
  input  rv_pkg::reg_idx_t rd,
  input  rv_pkg::word_t    wdata,
  input  rv_pkg::reg_idx_t rs1,
  input  rv_pkg::reg_idx_t rs2,
  output rv_pkg::word_t    rs1_data,
  output rv_pkg::word_t    rs2_data
);

  rv_pkg::word_t regs [rv_pkg::NUM_REGS];

  // x0 reads as zero whatever the array holds
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < rv_pkg::NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin
      regs[rd] <= wdata;
    end
  end

endmodule

//--- design/run_ctrl.sv
`timescale 1ns/1ps

module run_ctrl (
  input  logic             clk,
  input  logic             rst,
  input  logic             start,
  input  rv_pkg::prog_wr_t prog,
  input  logic             is_halt,
  input  logic             is_illegal,
  output rv_pkg::prog_wr_t mem_wr,
  output logic             exec,
  output logic             pc_clear,
  output logic             done,
  output logic             illegal
);

  rv_pkg::run_state_e state;
  logic               stop;

  assign exec     = (state == rv_pkg::RUN_ACTIVE);
  assign pc_clear = start && !exec;        // start ignored mid-run
  assign stop     = exec && (is_halt || is_illegal);

  // program writes blocked during a run
  always_comb begin
    mem_wr       = prog;
    mem_wr.valid = prog.valid && !exec;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= rv_pkg::RUN_IDLE;
      done    <= 1'b0;
      illegal <= 1'b0;
    end else begin
      done <= stop;
      if (pc_clear) begin
        state   <= rv_pkg::RUN_ACTIVE;
        illegal <= 1'b0;
      end else if (stop) begin
        state   <= rv_pkg::RUN_HALTED;
        illegal <= is_illegal; // held until the next start
      end
    end
  end

  a_done_single: assert property (@(posedge clk) disable iff (rst) done |=> !done)
    else $error("run_ctrl: done high for two cycles");

  a_no_load_in_run: assert property (@(posedge clk) disable iff (rst)
    !(mem_wr.valid && exec))
    else $error("run_ctrl: program write during run");

endmodule

//--- design/rv_core.sv
`timescale 1ns/1ps

module rv_core (
  input  logic             clk,
  input  logic             rst,
  input  logic             start,
  input  rv_pkg::prog_wr_t prog,
  output rv_pkg::retire_t  retire,
  output logic             retire_valid,
  output logic             done,
  output logic             illegal
);

  rv_pkg::prog_wr_t mem_wr;
  rv_pkg::decoded_t dec;
  rv_pkg::word_t    pc;
  rv_pkg::word_t    insn;
  rv_pkg::word_t    rs1_data;
  rv_pkg::word_t    rs2_data;
  rv_pkg::word_t    wdata;
  logic             exec;
  logic             pc_clear;
  logic             rf_we;

  assign rf_we = exec && dec.rd_we;

  run_ctrl u_run_ctrl (
    .clk(clk), .rst(rst), .start(start), .prog(prog),
    .is_halt(dec.is_halt), .is_illegal(dec.is_illegal),
    .mem_wr(mem_wr), .exec(exec), .pc_clear(pc_clear),
    .done(done), .illegal(illegal)
  );

  instr_mem u_instr_mem (.clk(clk), .mem_wr(mem_wr), .pc(pc), .insn(insn));

  insn_decode u_insn_decode (.insn(insn), .dec(dec));

  reg_file u_reg_file (
    .clk(clk), .rst(rst), .we(rf_we), .rd(dec.rd), .wdata(wdata),
    .rs1(dec.rs1), .rs2(dec.rs2), .rs1_data(rs1_data), .rs2_data(rs2_data)
  );

  alu u_alu (.dec(dec), .rs1_data(rs1_data), .rs2_data(rs2_data), .wdata(wdata));

  fetch_unit u_fetch_unit (
    .clk(clk), .rst(rst), .exec(exec), .pc_clear(pc_clear), .dec(dec),
    .rs1_data(rs1_data), .rs2_data(rs2_data), .pc(pc)
  );

  // retirement trace, one cycle behind execution
  always_ff @(posedge clk) begin
    if (rst) begin
      retire_valid <= 1'b0;
    end else begin
      retire_valid <= exec && !dec.is_halt && !dec.is_illegal;
    end
  end

  always_ff @(posedge clk) begin
    retire.pc    <= pc;
    retire.rd_we <= dec.rd_we;
    retire.rd    <= dec.rd;
    retire.wdata <= wdata;
  end

  a_no_x0_write: assert property (@(posedge clk) disable iff (rst)
    (retire_valid && retire.rd_we) |-> (retire.rd != '0))
    else $error("rv_core: retired write to x0");

endmodule

//--- design/rv_pkg.sv
package rv_pkg;

  localparam int XLEN       = 32;
  localparam int NUM_REGS   = 32;
  localparam int IMEM_WORDS = 64;

  typedef logic [XLEN-1:0]               word_t;
  typedef logic [$clog2(NUM_REGS)-1:0]   reg_idx_t;
  typedef logic [$clog2(IMEM_WORDS)-1:0] imem_addr_t;

  // major opcodes kept by this core
  typedef enum logic [6:0] {
    OP_LUI     = 7'b0110111,
    OP_REG_IMM = 7'b0010011,
    OP_REG_REG = 7'b0110011,
    OP_BRANCH  = 7'b1100011,
    OP_ENVIRON = 7'b1110011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_LUI
  } alu_op_e;

  typedef enum logic [1:0] {
    RUN_IDLE,
    RUN_ACTIVE,
    RUN_HALTED
  } run_state_e;

  typedef struct packed {
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    reg_idx_t   rd;
    word_t      imm;         // I-imm sign extended, U-imm for lui
    logic       use_imm;
    alu_op_e    alu_op;
    logic       rd_we;
    logic       is_branch;
    logic [2:0] funct3;      // branch condition
    word_t      br_off;
    logic       is_halt;
    logic       is_illegal;
  } decoded_t;

  typedef struct packed {
    logic       valid;
    imem_addr_t addr;
    word_t      data;
  } prog_wr_t;

  typedef struct packed {
    word_t    pc;
    logic     rd_we;
    reg_idx_t rd;
    word_t    wdata;
  } retire_t;

endpackage

//--- sim/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
  output logic clk
);

  localparam real HALF_PERIOD = 2.0; // 4 ns period

  initial clk = 1'b0;

  always #(HALF_PERIOD) clk = ~clk;

endmodule

//--- sim/tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core;

  localparam int MAX_STEPS  = 200;
  localparam int NUM_RUNS   = 8;
  localparam int RUN_CYCLES = rv_pkg::IMEM_WORDS + MAX_STEPS + 16;
  localparam rv_pkg::word_t ECALL   = 32'h0000_0073;
  localparam rv_pkg::word_t BAD_OPC = 32'hFFFF_FFFF;

  logic             clk;
  logic             rst;
  logic             start;
  rv_pkg::prog_wr_t prog;
  rv_pkg::retire_t  retire;
  logic             retire_valid;
  logic             done;
  logic             illegal;

  int            err_cnt;
  int            chk_cnt;
  rv_pkg::word_t rng_state;
  rv_pkg::word_t prog_q[$];
  rv_pkg::word_t img[rv_pkg::IMEM_WORDS];   // model copy of program memory
  rv_pkg::word_t mreg[rv_pkg::NUM_REGS];    // model register file

  // expected retire trace from the model
  rv_pkg::word_t    exp_pc[$];
  logic             exp_we[$];
  rv_pkg::reg_idx_t exp_rd[$];
  rv_pkg::word_t    exp_wd[$];
  logic             exp_alu[$];
  logic             exp_illegal;

  tb_clock u_clock (.clk(clk));

  rv_core UUT (
    .clk(clk), .rst(rst), .start(start), .prog(prog),
    .retire(retire), .retire_valid(retire_valid), .done(done), .illegal(illegal)
  );

  task automatic check_word(input string name, input rv_pkg::word_t exp, input rv_pkg::word_t act);
    chk_cnt++;
    if (exp !== act) begin
      err_cnt++;
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_idx(input string name, input rv_pkg::reg_idx_t exp,
                           input rv_pkg::reg_idx_t act);
    chk_cnt++;
    if (exp !== act) begin
      err_cnt++;
      $display("CHECK FAILED %s: expected x%0d, actual x%0d", name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    chk_cnt++;
    if (exp !== act) begin
      err_cnt++;
      $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  function automatic rv_pkg::word_t xorshift(input rv_pkg::word_t x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic rv_pkg::word_t rnd();
    rng_state = xorshift(rng_state);
    return rng_state;
  endfunction

  // instruction encoders
  function automatic rv_pkg::word_t enc_i(input int f3, input int rd, input int rs1, input int imm);
    return {12'(imm), 5'(rs1), 3'(f3), 5'(rd), 7'h13};
  endfunction

  function automatic rv_pkg::word_t enc_sh(input int f3, input logic alt, input int rd,
                                           input int rs1, input int sh);
    return {1'b0, alt, 5'b0, 5'(sh), 5'(rs1), 3'(f3), 5'(rd), 7'h13};
  endfunction

  function automatic rv_pkg::word_t enc_r(input int f3, input logic alt, input int rd,
                                          input int rs1, input int rs2);
    return {1'b0, alt, 5'b0, 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), 7'h33};
  endfunction

  function automatic rv_pkg::word_t enc_lui(input int rd, input int up);
    return {20'(up), 5'(rd), 7'h37};
  endfunction

  function automatic rv_pkg::word_t enc_b(input int f3, input int rs1, input int rs2,
                                          input int off);
    logic [12:0] o;
    o = 13'(off);
    return {o[12], o[10:5], 5'(rs2), 5'(rs1), 3'(f3), o[4:1], o[11], 7'h63};
  endfunction

  // lui+addi pair with the upper part rounded up when addi sign-extends negative
  task automatic emit_li(input int r, input rv_pkg::word_t v);
    logic [19:0] up;
    up = v[31:12] + 20'(v[11]);
    prog_q.push_back(enc_lui(r, int'(up)));
    prog_q.push_back(enc_i(0, r, r, int'(v[11:0])));
  endtask

  function automatic rv_pkg::word_t alu_ref(input logic [2:0] f3, input logic alt,
                                            input rv_pkg::word_t a, input rv_pkg::word_t b);
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: return (a < b) ? 32'd1 : 32'd0;
      3'd4: return a ^ b;
      3'd5: return alt ? rv_pkg::word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  // interprets img from pc 0 until a halt with registers carried over between runs
  task automatic model_run();
    rv_pkg::word_t pc;
    rv_pkg::word_t w;
    rv_pkg::word_t a;
    rv_pkg::word_t b;
    rv_pkg::word_t val;
    rv_pkg::word_t nxt;
    logic [2:0]    f3;
    logic [6:0]    f7;
    logic          is_alu;
    logic          ill;
    logic          halt;
    logic          cond;
    int            steps;
    exp_pc.delete();
    exp_we.delete();
    exp_rd.delete();
    exp_wd.delete();
    exp_alu.delete();
    exp_illegal = 1'b0;
    pc = '0;
    steps = 0;
    halt = 1'b0;
    ill = 1'b0;
    while (steps < MAX_STEPS && !halt && !ill) begin
      w = img[pc[7:2]];
      f3 = w[14:12];
      f7 = w[31:25];
      a = mreg[w[19:15]];
      is_alu = 1'b0;
      val = '0;
      nxt = pc + 32'd4;
      case (w[6:0])
        7'h37: begin
          is_alu = 1'b1;
          val = {w[31:12], 12'h000};
        end
        7'h13: begin
          is_alu = 1'b1;
          b = {{20{w[31]}}, w[31:20]};
          if (f3 == 3'd1) ill = (f7 != 7'h00);
          if (f3 == 3'd5) ill = (f7 != 7'h00) && (f7 != 7'h20);
          val = alu_ref(f3, w[30] && f3 == 3'd5, a, b);
        end
        7'h33: begin
          is_alu = 1'b1;
          ill = (f7 != 7'h00) && (f7 != 7'h20);
          val = alu_ref(f3, w[30], a, mreg[w[24:20]]);
        end
        7'h63: begin
          b = mreg[w[24:20]];
          case (f3)
            3'd0: cond = (a == b);
            3'd1: cond = (a != b);
            3'd4: cond = ($signed(a) < $signed(b));
            3'd5: cond = ($signed(a) >= $signed(b));
            3'd6: cond = (a < b);
            3'd7: cond = (a >= b);
            default: begin
              cond = 1'b0;
              ill = 1'b1;
            end
          endcase
          if (cond) nxt = pc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        end
        7'h73: begin
          halt = (w[31:7] == 25'd0);
          ill = !halt;
        end
        default: ill = 1'b1;
      endcase
      if (!halt && !ill) begin
        exp_pc.push_back(pc);
        exp_we.push_back(is_alu && w[11:7] != 5'd0);
        exp_rd.push_back(w[11:7]);
        exp_wd.push_back(val);
        exp_alu.push_back(is_alu);
        if (is_alu && w[11:7] != 5'd0) mreg[w[11:7]] = val;
        pc = nxt;
        steps++;
      end
    end
    exp_illegal = ill;
  endtask

  task automatic load_program();
    rv_pkg::prog_wr_t p;
    foreach (prog_q[i]) begin
      p.valid = 1'b1;
      p.addr  = rv_pkg::imem_addr_t'(i);
      p.data  = prog_q[i];
      img[i]  = prog_q[i];
      @(posedge clk);
      prog <= p;
    end
    @(posedge clk);
    prog <= '0;
  endtask

  // start a run, collect the trace until done and compare it with the model
  task automatic run_program(input string name, input logic inject);
    rv_pkg::prog_wr_t bad;
    int c;
    int idx;
    int first;
    logic got_done;
    bad.valid = 1'b1;
    bad.addr  = '0;
    bad.data  = BAD_OPC;
    model_run();
    c = 0;
    idx = 0;
    first = -1;
    got_done = 1'b0;
    @(posedge clk);
    start <= 1'b1;
    while (!got_done && c < MAX_STEPS + 8) begin
      @(posedge clk);
      c++;
      start <= 1'b0;
      prog <= (inject && c == 3) ? bad : '0;  // load attempt mid-run
      @(negedge clk);
      if (c == 1) check_flag({name, " illegal after start"}, 1'b0, illegal);
      if (retire_valid) begin
        if (first < 0) first = c;
        if (idx < exp_pc.size()) begin
          check_word({name, " pc"}, exp_pc[idx], retire.pc);
          check_flag({name, " rd_we"}, exp_we[idx], retire.rd_we);
          if (exp_alu[idx]) begin
            check_idx({name, " rd"}, exp_rd[idx], retire.rd);
            check_word({name, " wdata"}, exp_wd[idx], retire.wdata);
          end
        end
        idx++;
      end
      got_done = done;
    end
    if (!got_done) begin
      err_cnt++;
      $display("%s: done never came after start", name);
    end
    check_word({name, " retire count"}, rv_pkg::word_t'(exp_pc.size()), rv_pkg::word_t'(idx));
    check_flag({name, " first retire 2 cycles after start"}, 1'b1, first == 2);
    check_flag({name, " illegal"}, exp_illegal, illegal);
    repeat (3) begin
      @(negedge clk);
      if (retire_valid || done) begin
        err_cnt++;
        $display("%s: retire or done seen after the run halted", name);
      end
    end
  endtask

  task automatic test_reg_imm();
    rv_pkg::word_t v;
    int f3s[6];
    f3s = '{0, 2, 3, 4, 6, 7};
    prog_q.delete();
    for (int k = 0; k < 2; k++) begin
      emit_li(1, rnd());
      foreach (f3s[j]) begin
        v = rnd();
        prog_q.push_back(enc_i(f3s[j], 2 + j, 1, int'(v[11:0])));
      end
      v = rnd();
      prog_q.push_back(enc_sh(1, 1'b0, 8, 1, int'(v[4:0])));
      prog_q.push_back(enc_sh(5, 1'b0, 9, 1, int'(v[9:5])));
      prog_q.push_back(enc_sh(5, 1'b1, 10, 1, int'(v[14:10])));
      prog_q.push_back(enc_lui(11, int'(v[31:12])));
    end
    prog_q.push_back(ECALL);
    load_program();
    run_program("reg_imm", 1'b0);
  endtask

  task automatic test_reg_reg();
    int pa[4];
    int pb[4];
    pa = '{1, 3, 3, 2};
    pb = '{2, 1, 4, 5};
    prog_q.delete();
    emit_li(1, rnd());
    emit_li(2, rnd());
    emit_li(3, rnd() | 32'h8000_0000); // negative operand
    emit_li(4, 32'h0000_003F);         // shift amount 31
    emit_li(5, 32'h0000_0020);         // shift amount 32 wraps to 0
    foreach (pa[p]) begin
      for (int f = 0; f < 8; f++) begin
        prog_q.push_back(enc_r(f, 1'b0, 6 + f, pa[p], pb[p]));
      end
      prog_q.push_back(enc_r(0, 1'b1, 14, pa[p], pb[p]));  // sub
      prog_q.push_back(enc_r(5, 1'b1, 15, pa[p], pb[p]));  // sra
    end
    prog_q.push_back(ECALL);
    load_program();
    run_program("reg_reg", 1'b0);
  endtask

  task automatic test_branches();
    prog_q.delete();
    prog_q.push_back(enc_i(0, 1, 0, 5));      // 0
    prog_q.push_back(enc_i(0, 2, 0, -3));     // 4
    prog_q.push_back(enc_i(0, 3, 0, 0));      // 8
    prog_q.push_back(enc_b(0, 1, 1, 8));      // 12 beq taken
    prog_q.push_back(enc_i(0, 10, 0, 1));     // 16
    prog_q.push_back(enc_b(1, 1, 1, 8));      // 20 bne not taken
    prog_q.push_back(enc_b(4, 2, 1, 8));      // 24 blt taken
    prog_q.push_back(enc_i(0, 10, 0, 2));     // 28
    prog_q.push_back(enc_b(5, 2, 1, 8));      // 32 bge not taken
    prog_q.push_back(enc_b(6, 2, 1, 8));      // 36 bltu not taken
    prog_q.push_back(enc_b(7, 2, 1, 8));      // 40 bgeu taken
    prog_q.push_back(enc_i(0, 10, 0, 3));     // 44
    prog_q.push_back(enc_i(0, 3, 3, 1));      // 48 loop body
    prog_q.push_back(enc_b(6, 3, 1, -4));     // 52 bltu backward
    prog_q.push_back(enc_b(0, 3, 1, 8));      // 56 beq taken
    prog_q.push_back(enc_i(0, 10, 0, 4));     // 60
    prog_q.push_back(enc_b(0, 2, 1, 8));      // 64 beq not taken
    prog_q.push_back(enc_b(1, 2, 1, 8));      // 68 bne taken
    prog_q.push_back(enc_i(0, 10, 0, 5));     // 72
    prog_q.push_back(enc_b(4, 1, 2, 8));      // 76 blt not taken
    prog_q.push_back(enc_b(5, 1, 2, 8));      // 80 bge taken
    prog_q.push_back(enc_i(0, 10, 0, 6));     // 84
    prog_q.push_back(enc_b(7, 1, 2, 8));      // 88 bgeu not taken
    prog_q.push_back(ECALL);                  // 92
    load_program();
    run_program("branches", 1'b0);
  endtask

  task automatic test_x0();
    prog_q.delete();
    prog_q.push_back(enc_i(0, 0, 0, 123));
    prog_q.push_back(enc_lui(0, 32'h12345));
    emit_li(5, rnd());
    prog_q.push_back(enc_r(0, 1'b0, 6, 0, 5));
    prog_q.push_back(enc_r(0, 1'b0, 7, 5, 0));
    prog_q.push_back(enc_r(0, 1'b1, 8, 5, 0));
    prog_q.push_back(ECALL);
    load_program();
    run_program("x0", 1'b0);
  endtask

  task automatic test_ecall_rerun();
    prog_q.delete();
    prog_q.push_back(enc_i(0, 9, 9, 7));
    prog_q.push_back(enc_r(0, 1'b0, 12, 12, 9));
    prog_q.push_back(enc_i(0, 13, 9, -1));
    prog_q.push_back(enc_r(4, 1'b0, 14, 12, 13));
    prog_q.push_back(enc_sh(1, 1'b0, 15, 9, 3));
    prog_q.push_back(enc_r(6, 1'b0, 16, 15, 12));
    prog_q.push_back(ECALL);
    load_program();
    run_program("ecall_run", 1'b1);
    run_program("ecall_rerun", 1'b0); // same code on the registers left by the first run
  endtask

  task automatic test_illegal();
    prog_q.delete();
    prog_q.push_back(enc_i(0, 17, 0, 9));
    prog_q.push_back(enc_i(0, 18, 17, 1));
    prog_q.push_back(BAD_OPC);
    load_program();
    run_program("illegal", 1'b0);
    prog_q.delete();
    prog_q.push_back(enc_i(0, 19, 0, 4));
    prog_q.push_back(ECALL);
    load_program();
    run_program("after_illegal", 1'b0);
  endtask

  initial begin
    #(NUM_RUNS * RUN_CYCLES * 4 + 100);
    $display("watchdog expired before the tests finished");
    $display("Simulation finished: FAIL");
    $finish;
  end

  initial begin
    err_cnt = 0;
    chk_cnt = 0;
    rng_state = 32'd11;
    rst = 1'b1;
    start = 1'b0;
    prog = '0;
    for (int i = 0; i < rv_pkg::NUM_REGS; i++) mreg[i] = '0;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    test_reg_imm();
    test_reg_reg();
    test_branches();
    test_x0();
    test_ecall_rerun();
    test_illegal();
    $display("checks: %0d errors: %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

//--- src.f
design/rv_pkg.sv
design/instr_mem.sv
design/insn_decode.sv
design/reg_file.sv
design/alu.sv
design/fetch_unit.sv
design/run_ctrl.sv
design/rv_core.sv
sim/tb_clock.sv
sim/tb_rv_core.sv
